// File: source/linear_pkg.sv
package linear_pkg;

  // accumulator group state
  // empty: no partial sum of the current group taken yet
  // filling: at least one partial sum taken, more to come
  // full: result held until the consumer takes it
  typedef enum logic [1:0] {
    acc_empty   = 2'd0,
    acc_filling = 2'd1,
    acc_full    = 2'd2
  } acc_state_t;

  // default layer dimensions, used as parameter defaults
  // signed input element width
  localparam int default_in_width = 8;

  // signed weight element width
  localparam int default_weight_width = 8;

  // elements per input beat
  localparam int default_in_size = 4;

  // beats per output value
  localparam int default_in_depth = 3;

  // output lanes computed side by side
  localparam int default_parallelism = 2;

endpackage

// File: source/fixed_dot_product.sv
module fixed_dot_product #(
  parameter int  IN_WIDTH     = linear_pkg::default_in_width,
  parameter int  WEIGHT_WIDTH = linear_pkg::default_weight_width,
  parameter int  IN_SIZE      = linear_pkg::default_in_size,
  localparam int OUT_WIDTH    = IN_WIDTH + WEIGHT_WIDTH + $clog2(IN_SIZE)
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic [IN_WIDTH-1:0]     data_in [IN_SIZE-1:0],
  input  logic                    data_in_valid,
  output logic                    data_in_ready,

  input  logic [WEIGHT_WIDTH-1:0] weight [IN_SIZE-1:0],
  input  logic                    weight_valid,
  output logic                    weight_ready,

  output logic [OUT_WIDTH-1:0]    data_out,
  output logic                    data_out_valid,
  input  logic                    data_out_ready
);

  localparam int PROD_WIDTH = IN_WIDTH + WEIGHT_WIDTH;
  localparam int LEVELS     = $clog2(IN_SIZE);
  localparam int LEAVES     = 1 << LEVELS;

  logic join_valid;
  logic accept;
  logic fire;

  logic signed [PROD_WIDTH-1:0] product [IN_SIZE-1:0];

  // adder tree stored heap style
  // node 1 is the root, leaves sit at LEAVES .. 2*LEAVES-1
  logic signed [OUT_WIDTH-1:0]  node [1:2*LEAVES-1];

  // join of the data and weight channels
  assign join_valid = data_in_valid & weight_valid;

  // output register is free or being drained this cycle
  assign accept = ~data_out_valid | data_out_ready;
  assign fire   = join_valid & accept;

  // each channel only sees ready once its partner is valid too,
  // so a data/weight pair always moves on the same edge
  assign data_in_ready = weight_valid & accept;
  assign weight_ready  = data_in_valid & accept;

  for (genvar k = 0; k < IN_SIZE; k++) begin : g_mul
    assign product[k] = $signed(data_in[k]) * $signed(weight[k]);
  end

  // leaves take the sign-extended products, padding leaves are zero
  for (genvar k = 0; k < LEAVES; k++) begin : g_leaf
    if (k < IN_SIZE) begin : g_used
      assign node[LEAVES+k] = product[k];
    end else begin : g_pad
      assign node[LEAVES+k] = '0;
    end
  end

  for (genvar k = 1; k < LEAVES; k++) begin : g_node
    assign node[k] = node[2*k] + node[2*k+1];
  end

  // output valid flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out_valid <= 1'b0;
    end else if (accept) begin
      data_out_valid <= join_valid;
    end
  end

  // partial sum register, only loaded on a transfer
  always_ff @(posedge clk) begin
    if (fire) begin
      data_out <= node[1];
    end
  end

endmodule

// File: source/fixed_accumulator.sv
module fixed_accumulator #(
  parameter int  IN_WIDTH  = linear_pkg::default_in_width + linear_pkg::default_weight_width,
  parameter int  IN_DEPTH  = linear_pkg::default_in_depth,
  localparam int OUT_WIDTH = IN_WIDTH + $clog2(IN_DEPTH)
) (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic [IN_WIDTH-1:0]  data_in,
  input  logic                 data_in_valid,
  output logic                 data_in_ready,

  output logic [OUT_WIDTH-1:0] data_out,
  output logic                 data_out_valid,
  input  logic                 data_out_ready
);

  import linear_pkg::*;

  // counter needs at least one bit even for a depth of one
  localparam int CNT_WIDTH = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

  acc_state_t state;

  logic [CNT_WIDTH-1:0]        beat_count;
  logic                        in_fire;
  logic                        out_fire;
  logic                        first_beat;
  logic                        last_beat;
  logic signed [OUT_WIDTH-1:0] sum_ext;
  logic signed [OUT_WIDTH-1:0] acc_sum;

  assign data_out_valid = (state == acc_full);

  // while full, a new group may only start as the result leaves
  assign data_in_ready = (state != acc_full) | data_out_ready;

  assign in_fire  = data_in_valid & data_in_ready;
  assign out_fire = data_out_valid & data_out_ready;

  assign first_beat = (state != acc_filling);
  assign last_beat  = (beat_count == CNT_WIDTH'(IN_DEPTH - 1));

  assign sum_ext  = $signed(data_in);
  assign data_out = acc_sum;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= acc_empty;
      beat_count <= '0;
    end else if (in_fire) begin
      if (last_beat) begin
        state      <= acc_full;
        beat_count <= '0;
      end else begin
        state      <= acc_filling;
        beat_count <= beat_count + 1'b1;
      end
    end else if (out_fire) begin
      state <= acc_empty;
    end
  end

  // first beat of a group overwrites the previous result
  always_ff @(posedge clk) begin
    if (in_fire) begin
      if (first_beat) begin
        acc_sum <= sum_ext;
      end else begin
        acc_sum <= acc_sum + sum_ext;
      end
    end
  end

endmodule

// File: source/bias_adder.sv
module bias_adder #(
  parameter int  IN_WIDTH  = linear_pkg::default_in_width + linear_pkg::default_weight_width,
  parameter int  B_WIDTH   = IN_WIDTH,
  localparam int OUT_WIDTH = ((IN_WIDTH > B_WIDTH) ? IN_WIDTH : B_WIDTH) + 1
) (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic [IN_WIDTH-1:0]  acc_in,
  input  logic                 acc_valid,
  output logic                 acc_ready,

  input  logic [B_WIDTH-1:0]   bias,
  input  logic                 bias_valid,
  output logic                 bias_ready,

  output logic [OUT_WIDTH-1:0] data_out,
  output logic                 data_out_valid,
  input  logic                 data_out_ready
);

  logic join_valid;
  logic accept;
  logic fire;

  logic signed [OUT_WIDTH-1:0] acc_ext;
  logic signed [OUT_WIDTH-1:0] bias_ext;
  logic signed [OUT_WIDTH-1:0] sum;

  // join of the accumulated result with its bias
  assign join_valid = acc_valid & bias_valid;

  // slice is empty or its content leaves this cycle
  assign accept = ~data_out_valid | data_out_ready;
  assign fire   = join_valid & accept;

  assign acc_ready  = bias_valid & accept;
  assign bias_ready = acc_valid & accept;

  // both operands widened with their sign before the add
  assign acc_ext  = $signed(acc_in);
  assign bias_ext = $signed(bias);
  assign sum      = acc_ext + bias_ext;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out_valid <= 1'b0;
    end else if (accept) begin
      data_out_valid <= join_valid;
    end
  end

  // held while the consumer stalls
  always_ff @(posedge clk) begin
    if (fire) begin
      data_out <= sum;
    end
  end

endmodule

// File: source/fixed_linear.sv
module fixed_linear #(
  parameter int  IN_WIDTH     = linear_pkg::default_in_width,
  parameter int  WEIGHT_WIDTH = linear_pkg::default_weight_width,
  parameter int  IN_SIZE      = linear_pkg::default_in_size,
  parameter int  IN_DEPTH     = linear_pkg::default_in_depth,
  parameter int  PARALLELISM  = linear_pkg::default_parallelism,
  parameter int  HAS_BIAS     = 0,

  // widths grow through the pipeline so nothing overflows
  localparam int FDP_WIDTH    = IN_WIDTH + WEIGHT_WIDTH + $clog2(IN_SIZE),
  localparam int ACC_WIDTH    = FDP_WIDTH + $clog2(IN_DEPTH),
  localparam int B_WIDTH      = ACC_WIDTH,
  localparam int OUT_WIDTH    = ACC_WIDTH + HAS_BIAS
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic [IN_WIDTH-1:0]     data_in [IN_SIZE-1:0],
  input  logic                    data_in_valid,
  output logic                    data_in_ready,

  // transposed and partitioned, lane i reads slice i
  input  logic [WEIGHT_WIDTH-1:0] weight [IN_SIZE*PARALLELISM-1:0],
  input  logic                    weight_valid,
  output logic                    weight_ready,

  input  logic [B_WIDTH-1:0]      bias [PARALLELISM-1:0],
  input  logic                    bias_valid,
  output logic                    bias_ready,

  output logic [OUT_WIDTH-1:0]    data_out [PARALLELISM-1:0],
  output logic                    data_out_valid,
  input  logic                    data_out_ready
);

  // per-lane handshakes, lanes run in lockstep
  logic [PARALLELISM-1:0] fdp_data_ready;
  logic [PARALLELISM-1:0] fdp_weight_ready;
  logic [PARALLELISM-1:0] acc_valid;
  logic [ACC_WIDTH-1:0]   acc_out [PARALLELISM-1:0];

  // shared ready into every accumulator output
  logic acc_ready;

  // lane 0 stands for all lanes
  assign data_in_ready = fdp_data_ready[0];
  assign weight_ready  = fdp_weight_ready[0];

  for (genvar i = 0; i < PARALLELISM; i++) begin : g_lane
    logic [WEIGHT_WIDTH-1:0] lane_weight [IN_SIZE-1:0];
    logic [FDP_WIDTH-1:0]    fdp_out;
    logic                    fdp_valid;
    logic                    fdp_ready;

    assign lane_weight = weight[IN_SIZE*i+IN_SIZE-1:IN_SIZE*i];

    fixed_dot_product #(
      .IN_WIDTH     (IN_WIDTH),
      .WEIGHT_WIDTH (WEIGHT_WIDTH),
      .IN_SIZE      (IN_SIZE)
    ) u_fdp (
      .clk            (clk),
      .rst_n          (rst_n),
      .data_in        (data_in),
      .data_in_valid  (data_in_valid),
      .data_in_ready  (fdp_data_ready[i]),
      .weight         (lane_weight),
      .weight_valid   (weight_valid),
      .weight_ready   (fdp_weight_ready[i]),
      .data_out       (fdp_out),
      .data_out_valid (fdp_valid),
      .data_out_ready (fdp_ready)
    );

    fixed_accumulator #(
      .IN_WIDTH (FDP_WIDTH),
      .IN_DEPTH (IN_DEPTH)
    ) u_acc (
      .clk            (clk),
      .rst_n          (rst_n),
      .data_in        (fdp_out),
      .data_in_valid  (fdp_valid),
      .data_in_ready  (fdp_ready),
      .data_out       (acc_out[i]),
      .data_out_valid (acc_valid[i]),
      .data_out_ready (acc_ready)
    );
  end

  if (HAS_BIAS == 1) begin : g_bias
    logic [PARALLELISM-1:0] lane_acc_ready;
    logic [PARALLELISM-1:0] lane_bias_ready;
    logic [PARALLELISM-1:0] lane_out_valid;

    assign acc_ready      = lane_acc_ready[0];
    assign bias_ready     = lane_bias_ready[0];
    assign data_out_valid = lane_out_valid[0];

    for (genvar i = 0; i < PARALLELISM; i++) begin : g_add
      // every slice sees the lane 0 accumulator valid
      bias_adder #(
        .IN_WIDTH (ACC_WIDTH),
        .B_WIDTH  (B_WIDTH)
      ) u_bias (
        .clk            (clk),
        .rst_n          (rst_n),
        .acc_in         (acc_out[i]),
        .acc_valid      (acc_valid[0]),
        .acc_ready      (lane_acc_ready[i]),
        .bias           (bias[i]),
        .bias_valid     (bias_valid),
        .bias_ready     (lane_bias_ready[i]),
        .data_out       (data_out[i]),
        .data_out_valid (lane_out_valid[i]),
        .data_out_ready (data_out_ready)
      );
    end
  end else begin : g_no_bias
    // accumulators drive the outputs directly
    assign acc_ready      = data_out_ready;
    assign data_out_valid = acc_valid[0];
    assign bias_ready     = 1'b1;

    for (genvar i = 0; i < PARALLELISM; i++) begin : g_out
      assign data_out[i] = acc_out[i];
    end
  end

endmodule

// File: test/fixed_linear_asserts.sv
module fixed_linear_asserts #(
  parameter int PARALLELISM = linear_pkg::default_parallelism,
  parameter int OUT_WIDTH   = 21
) (
  input logic                   clk,
  input logic                   rst_n,
  input logic [PARALLELISM-1:0] fdp_data_ready,
  input logic [PARALLELISM-1:0] acc_valid,
  input linear_pkg::acc_state_t acc_state_first,
  input linear_pkg::acc_state_t acc_state_last,
  input logic                   data_out_valid,
  input logic                   data_out_ready,
  input logic [OUT_WIDTH-1:0]   data_out_lane0
);

  // a stalled output beat keeps its valid and its value
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out_lane0))
    else $error("data_out changed or dropped while stalled");

  // every dot-product lane accepts on the same edge
  a_lane_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (fdp_data_ready == '0) || (fdp_data_ready == '1))
    else $error("dot-product readies differ between lanes");

  // lanes in lockstep
  a_lane_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (acc_valid == '0) || (acc_valid == '1))
    else $error("accumulator valids differ between lanes");

  a_lane_state: assert property (@(posedge clk) disable iff (!rst_n)
    acc_state_first == acc_state_last)
    else $error("accumulator states differ between lanes");

endmodule

// File: test/fixed_linear_checker.sv
module fixed_linear_checker #(
  parameter int PARALLELISM = 2,
  parameter int OUT_WIDTH   = 21
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic [OUT_WIDTH-1:0] data_out [PARALLELISM-1:0],
  input logic                 data_out_valid,
  input logic                 data_out_ready
);

  // expected values, PARALLELISM entries per output beat, lane 0 first
  longint expected [$];

  string test_name    = "none";
  int    test_beats   = 0;
  int    test_errors  = 0;
  int    total_beats  = 0;
  int    total_errors = 0;
  int    tests_run    = 0;

  function automatic void push_expected(longint value);
    expected.push_back(value);
  endfunction

  function automatic int pending();
    return expected.size();
  endfunction

  function automatic void start_test(string name);
    test_name   = name;
    test_beats  = 0;
    test_errors = 0;
  endfunction

  function automatic void note_failure(string msg);
    $display("%s", msg);
    test_errors++;
    total_errors++;
  endfunction

  function automatic void report_test(int groups_sent);
    if (test_beats != groups_sent) begin
      note_failure($sformatf("test %s received %0d results for %0d groups sent",
                             test_name, test_beats, groups_sent));
    end
    $display("test %-10s %0d beats, %0d errors", test_name, test_beats, test_errors);
    tests_run++;
  endfunction

  // values are stable between the falling edge and the transfer edge
  always @(negedge clk) begin : compare
    longint exp_value;
    longint act_value;
    if (rst_n && data_out_valid && data_out_ready) begin
      if (expected.size() < PARALLELISM) begin
        note_failure($sformatf("test %s produced an output beat with no group pending",
                               test_name));
      end else begin
        for (int l = 0; l < PARALLELISM; l++) begin
          exp_value = expected.pop_front();
          act_value = longint'($signed(data_out[l]));
          if (exp_value != act_value) begin
            $display("** Error test %s lane %0d: expected %0d, actual %0d",
                     test_name, l, exp_value, act_value);
            test_errors++;
            total_errors++;
          end
        end
      end
      test_beats++;
      total_beats++;
    end
  end

endmodule

// File: test/fixed_linear_tb.sv
module fixed_linear_tb;

  import linear_pkg::*;

  parameter int HAS_BIAS = 1;

  localparam int IN_WIDTH     = default_in_width;
  localparam int WEIGHT_WIDTH = default_weight_width;
  localparam int IN_SIZE      = default_in_size;
  localparam int IN_DEPTH     = default_in_depth;
  localparam int PARALLELISM  = default_parallelism;
  localparam int FDP_WIDTH    = IN_WIDTH + WEIGHT_WIDTH + $clog2(IN_SIZE);
  localparam int ACC_WIDTH    = FDP_WIDTH + $clog2(IN_DEPTH);
  localparam int B_WIDTH      = ACC_WIDTH;
  localparam int OUT_WIDTH    = ACC_WIDTH + HAS_BIAS;

  localparam int MAX_GROUPS     = 256;
  localparam int TOTAL_GROUPS   = 244;
  localparam int TIMEOUT_CYCLES = TOTAL_GROUPS * IN_DEPTH * 20 + 500;

  logic                    clk;
  logic                    rst_n;
  logic [IN_WIDTH-1:0]     data_in [IN_SIZE-1:0];
  logic                    data_in_valid;
  logic                    data_in_ready;
  logic [WEIGHT_WIDTH-1:0] weight [IN_SIZE*PARALLELISM-1:0];
  logic                    weight_valid;
  logic                    weight_ready;
  logic [B_WIDTH-1:0]      bias [PARALLELISM-1:0];
  logic                    bias_valid;
  logic                    bias_ready;
  logic [OUT_WIDTH-1:0]    data_out [PARALLELISM-1:0];
  logic                    data_out_valid;
  logic                    data_out_ready;
  bit                      ready_random;
  bit                      ready_stall;

  // stimulus per group, weights already split per lane
  logic signed [IN_WIDTH-1:0]     stim_data [MAX_GROUPS][IN_DEPTH][IN_SIZE];
  logic signed [WEIGHT_WIDTH-1:0] stim_weight [MAX_GROUPS][IN_DEPTH][IN_SIZE*PARALLELISM];
  logic signed [B_WIDTH-1:0]      stim_bias [MAX_GROUPS][PARALLELISM];

  fixed_linear #(
    .IN_WIDTH (IN_WIDTH), .WEIGHT_WIDTH (WEIGHT_WIDTH), .IN_SIZE (IN_SIZE),
    .IN_DEPTH (IN_DEPTH), .PARALLELISM (PARALLELISM), .HAS_BIAS (HAS_BIAS)
  ) dut0 (.*);

  fixed_linear_checker #(.PARALLELISM (PARALLELISM), .OUT_WIDTH (OUT_WIDTH)) chk0 (
    .clk (clk), .rst_n (rst_n), .data_out (data_out),
    .data_out_valid (data_out_valid), .data_out_ready (data_out_ready)
  );

  bind fixed_linear fixed_linear_asserts #(
    .PARALLELISM (PARALLELISM), .OUT_WIDTH (OUT_WIDTH)
  ) u_asserts (
    .clk (clk), .rst_n (rst_n),
    .fdp_data_ready (fdp_data_ready),
    .acc_valid (acc_valid),
    .acc_state_first (g_lane[0].u_acc.state),
    .acc_state_last (g_lane[PARALLELISM-1].u_acc.state),
    .data_out_valid (data_out_valid), .data_out_ready (data_out_ready),
    .data_out_lane0 (data_out[0])
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog: run timed out after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  always @(posedge clk) begin
    #2;
    if (ready_stall) begin
      data_out_ready = 1'b0;
    end else begin
      data_out_ready = ready_random ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  // mode 0 zero bias, mode 1 extreme values with negative bias, mode 2 random
  function automatic logic [31:0] pick_value(int mode, int width);
    logic [31:0] v;
    v = $urandom;
    if (mode == 1) begin
      case ($urandom_range(0, 3))
        0: v = 32'd1 << (width - 1);
        1: v = (32'd1 << (width - 1)) - 1;
        default: v = $urandom;
      endcase
    end
    return v;
  endfunction

  task automatic gen_group(int g, int mode);
    longint b;
    for (int d = 0; d < IN_DEPTH; d++) begin
      for (int k = 0; k < IN_SIZE; k++) begin
        stim_data[g][d][k] = IN_WIDTH'(pick_value(mode, IN_WIDTH));
      end
      for (int k = 0; k < IN_SIZE * PARALLELISM; k++) begin
        stim_weight[g][d][k] = WEIGHT_WIDTH'(pick_value(mode, WEIGHT_WIDTH));
      end
    end
    for (int l = 0; l < PARALLELISM; l++) begin
      if (mode == 0) b = 0;
      else if (mode == 1) b = -longint'($urandom_range(1, 65535));
      else b = longint'($urandom_range(0, 131071)) - 65536;
      stim_bias[g][l] = b[B_WIDTH-1:0];
    end
  endtask

  // sum over depth of the lane's dot products, plus bias when present
  function automatic longint ref_sum(int g, int lane);
    longint acc;
    acc = 0;
    for (int d = 0; d < IN_DEPTH; d++) begin
      for (int k = 0; k < IN_SIZE; k++) begin
        acc += longint'(stim_data[g][d][k]) * longint'(stim_weight[g][d][lane*IN_SIZE+k]);
      end
    end
    if (HAS_BIAS == 1) acc += longint'(stim_bias[g][lane]);
    return acc;
  endfunction

  task automatic drive_data(int first, int n, int beats, int gap_max);
    bit seen;
    for (int g = first; g < first + n; g++) begin
      for (int d = 0; d < beats; d++) begin
        for (int k = 0; k < IN_SIZE; k++) data_in[k] = stim_data[g][d][k];
        data_in_valid = 1'b1;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk);
          seen = data_in_ready;
          @(posedge clk);
          #2;
        end
        data_in_valid = 1'b0;
        repeat ($urandom_range(0, gap_max)) begin
          @(posedge clk);
          #2;
        end
      end
    end
  endtask

  task automatic drive_weight(int first, int n, int beats, int gap_max);
    bit seen;
    for (int g = first; g < first + n; g++) begin
      for (int d = 0; d < beats; d++) begin
        for (int k = 0; k < IN_SIZE * PARALLELISM; k++) weight[k] = stim_weight[g][d][k];
        weight_valid = 1'b1;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk);
          seen = weight_ready;
          @(posedge clk);
          #2;
        end
        weight_valid = 1'b0;
        repeat ($urandom_range(0, gap_max)) begin
          @(posedge clk);
          #2;
        end
      end
    end
  endtask

  task automatic drive_bias(int first, int n, int gap_max);
    bit seen;
    for (int g = first; g < first + n; g++) begin
      for (int l = 0; l < PARALLELISM; l++) bias[l] = stim_bias[g][l];
      bias_valid = 1'b1;
      seen = 1'b0;
      while (!seen) begin
        @(negedge clk);
        seen = bias_ready;
        @(posedge clk);
        #2;
      end
      bias_valid = 1'b0;
      repeat ($urandom_range(0, gap_max)) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic run_groups(string name, int first, int n, int mode,
                            int dgap, int wgap, bit rnd_ready);
    chk0.start_test(name);
    ready_random = rnd_ready;
    for (int g = first; g < first + n; g++) begin
      gen_group(g, mode);
      for (int l = 0; l < PARALLELISM; l++) chk0.push_expected(ref_sum(g, l));
    end
    fork
      drive_data(first, n, IN_DEPTH, dgap);
      drive_weight(first, n, IN_DEPTH, wgap);
      drive_bias(first, n, dgap);
    join
    while (chk0.pending() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    #2;
    chk0.report_test(n);
  endtask

  initial begin
    void'($urandom(48453));
    rst_n          = 1'b0;
    data_in_valid  = 1'b0;
    weight_valid   = 1'b0;
    bias_valid     = 1'b0;
    data_out_ready = 1'b1;
    ready_random   = 1'b0;
    ready_stall    = 1'b0;
    for (int k = 0; k < IN_SIZE; k++) data_in[k] = '0;
    for (int k = 0; k < IN_SIZE * PARALLELISM; k++) weight[k] = '0;
    for (int l = 0; l < PARALLELISM; l++) bias[l] = '0;
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;

    run_groups("single", 0, 1, 0, 0, 0, 1'b0);
    run_groups("extremes", 1, 20, 1, 1, 1, 1'b0);
    run_groups("lag", 21, 20, 2, 1, 5, 1'b0);
    run_groups("stream", 41, 200, 2, 2, 2, 1'b1);

    // a finished group parked at the stalled output, one beat of the
    // next group behind it, then reset before that group completes
    ready_stall = 1'b1;
    gen_group(241, 2);
    gen_group(242, 2);
    fork
      drive_data(241, 1, IN_DEPTH, 0);
      drive_weight(241, 1, IN_DEPTH, 0);
      drive_bias(241, 1, 0);
    join
    fork
      drive_data(242, 1, 1, 0);
      drive_weight(242, 1, 1, 0);
    join
    while (!data_out_valid) begin
      @(posedge clk);
      #2;
    end
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    @(negedge clk);
    if (data_out_valid) begin
      chk0.note_failure("data_out_valid is still high after the mid-group reset");
    end
    ready_stall = 1'b0;
    @(posedge clk);
    #2;
    run_groups("reset", 243, 1, 2, 0, 0, 1'b0);

    $display("summary: %0d tests, %0d beats, %0d errors",
             chk0.tests_run, chk0.total_beats, chk0.total_errors);
    if (chk0.total_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: fixed_linear.f
source/linear_pkg.sv
source/fixed_dot_product.sv
source/fixed_accumulator.sv
source/bias_adder.sv
source/fixed_linear.sv
test/fixed_linear_asserts.sv
test/fixed_linear_checker.sv
test/fixed_linear_tb.sv
